// ==== test/sm83_golden.hex ====
// program: start address, byte count, bytes; count 0 ends the program
// then expected writes: address, data; data ffff ends the list
0000 10 21 00 80 3E 3A 06 C6 80 77 3E 0F CE 01 2E 01 77
0010 10 06 20 37 98 2E 02 77 FE F0 2E 03 77 28 02 36 EE
0020 10 2E 04 38 02 36 A5 A6 2E 05 77 36 7F 34 35 37 0E
0030 10 FF 0C 38 02 36 11 2E 06 71 15 72 5A 2E 07 73 11
0040 10 34 12 01 78 56 2E 08 72 71 7E 2F 3F 2E 09 77 CB
0050 10 07 77 CB 1F 77 CB 37 77 CB 26 CB 3E CB 2E CB 46
0060 10 20 02 36 B1 CB 7E 28 02 CB 86 CB F8 70 CB A0 70
0070 10 3E 03 2E 0A 3D 77 20 FC C3 80 00 36 DD 76 00 00
0080 0F 2E 0B 36 5A 18 02 36 EE AF F6 81 D6 01 77 76
0000 0
8000 00 8001 11 8002 F0 8003 F0
8004 A5 8005 A0 8005 7F 8005 80
8005 7F 8006 00 8006 FF 8007 FF
8008 12 8008 78 8009 87 8009 0F
8009 87 8009 78 8009 F0 8009 78
8009 3C 8009 B1 8009 B0 8009 D6
8009 C6 800A 02 800A 01 800A 00
800B 5A 800B 80
0000 FFFF

// ==== sources.f ====
hdl/sm83_pkg.sv
hdl/sm83_bus_if.sv
hdl/sm83_decode.sv
hdl/sm83_alu.sv
hdl/sm83_regfile.sv
hdl/sm83_bus_master.sv
hdl/sm83_control.sv
hdl/sm83_core_top.sv
test/sm83_props.sv
test/tb_sm83.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sm83
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM) test/sm83_golden.hex
	./$(SIM) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_sm83.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sm83;

	logic        clk;
	logic        reset;
	logic        awvalid;
	logic        awready;
	logic [15:0] awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [15:0] araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        halted;

	// ------------------------------
	// memory model state
	// ------------------------------
	logic [7:0]  mem [0:65535];
	logic [15:0] gold [0:1023];
	logic [15:0] exp_addr [$];
	logic [7:0]  exp_data [$];
	int          wr_idx;
	int          prog_bytes;
	int          cycle_limit;
	int          cycles;
	integer      seed = 32'h85d8_c527;

	// per-channel handshake tracking
	logic        aw_seen;
	logic        w_seen;
	logic        ar_seen;
	logic        have_aw;
	logic        have_w;
	logic [15:0] wr_addr;
	logic [15:0] rd_addr;
	logic [31:0] wr_word;
	logic [3:0]  wr_strb;
	logic        b_pend;
	logic        rd_pend;
	int          aw_wait;
	int          w_wait;
	int          ar_wait;
	int          b_wait;
	int          r_wait;

	sm83_core_top uut (
		.clk(clk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// 0 to 3 cycles of stall
	function int pick_delay();
		pick_delay = $unsigned($random(seed)) % 4;
	endfunction

	task stop_on_failure();
		$display("Regression failed");
		$fatal(1);
	endtask

	// fill, then program records, then expected writes
	task load_golden();
		int idx;
		int n;
		for (int i = 0; i < 65536; i++) begin
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
		end
		$readmemh("test/sm83_golden.hex", gold);
		idx = 0;
		prog_bytes = 0;
		while (gold[idx + 1] !== 16'h0000) begin
			n = gold[idx + 1];
			for (int k = 0; k < n; k++) begin
				mem[gold[idx] + 16'(k)] = gold[idx + 2 + k][7:0];
			end
			prog_bytes += n;
			idx += 2 + n;
		end
		idx += 2;
		// data word ffff ends the write list
		while (gold[idx + 1] !== 16'hffff) begin
			exp_addr.push_back(gold[idx]);
			exp_data.push_back(gold[idx + 1][7:0]);
			idx += 2;
		end
		cycle_limit = 40 * prog_bytes + 2000;
	endtask

	task automatic check_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
		logic [7:0] b;
		b = d[{a[1:0], 3'b000} +: 8];
		assert ($onehot(s) && s[a[1:0]]) else begin
			$display("byte strobe %b does not select the lane of address %h", s, a);
			stop_on_failure();
		end
		assert (d == {4{b}}) else begin
			$display("write data %h is not one byte copied to all four lanes", d);
			stop_on_failure();
		end
		assert (wr_idx < exp_addr.size()) else begin
			$display("write to %h past the end of the expected list", a);
			stop_on_failure();
		end
		assert (a == exp_addr[wr_idx] && b == exp_data[wr_idx]) else begin
			$display("MISMATCH at %0t ns: write %h <= %h, expected %h <= %h",
				$time, a, b, exp_addr[wr_idx], exp_data[wr_idx]);
			stop_on_failure();
		end
		mem[a] = b;
		wr_idx++;
	endtask

	// ------------------------------
	// AXI slave, all on falling edge
	// ------------------------------
	always @(negedge clk) begin
		if (reset) begin
			{have_aw, have_w, b_pend, rd_pend} = 4'b0000;
			{aw_seen, w_seen, ar_seen} = 3'b000;
		end else begin
			// master always takes responses
			assert (bready && rready) else begin
				$display("bready or rready is low outside reset");
				stop_on_failure();
			end
			// handshakes from the last rising edge
			if (awready && aw_seen) begin
				have_aw = 1'b1;
				wr_addr = awaddr;
			end
			if (wready && w_seen) begin
				have_w  = 1'b1;
				wr_word = wdata;
				wr_strb = wstrb;
			end
			if (arready && ar_seen) begin
				rd_pend = 1'b1;
				rd_addr = araddr;
				r_wait  = pick_delay();
			end
			if (bvalid && bready)
				bvalid = 1'b0;
			if (rvalid && rready)
				rvalid = 1'b0;
			// both halves in, commit the byte
			if (have_aw && have_w) begin
				check_write(wr_addr, wr_word, wr_strb);
				{have_aw, have_w} = 2'b00;
				b_pend = 1'b1;
				b_wait = pick_delay();
			end
			if (b_pend && !bvalid) begin
				if (b_wait == 0) begin
					bvalid = 1'b1;
					b_pend = 1'b0;
				end else
					b_wait--;
			end
			// full aligned word back, DUT picks the lane
			if (rd_pend && !rvalid) begin
				if (r_wait == 0) begin
					rdata = {mem[{rd_addr[15:2], 2'b11}], mem[{rd_addr[15:2], 2'b10}],
						mem[{rd_addr[15:2], 2'b01}], mem[{rd_addr[15:2], 2'b00}]};
					rvalid  = 1'b1;
					rd_pend = 1'b0;
				end else
					r_wait--;
			end
			// readies after a random wait
			if (awready) begin
				awready = 1'b0;
				aw_wait = pick_delay();
			end else if (awvalid && !have_aw) begin
				if (aw_wait == 0)
					awready = 1'b1;
				else
					aw_wait--;
			end
			if (wready) begin
				wready = 1'b0;
				w_wait = pick_delay();
			end else if (wvalid && !have_w) begin
				if (w_wait == 0)
					wready = 1'b1;
				else
					w_wait--;
			end
			if (arready) begin
				arready = 1'b0;
				ar_wait = pick_delay();
			end else if (arvalid && !rd_pend) begin
				if (ar_wait == 0)
					arready = 1'b1;
				else
					ar_wait--;
			end
			aw_seen = awvalid;
			w_seen  = wvalid;
			ar_seen = arvalid;
		end
	end

	// run limit
	initial begin
		cycles = 0;
		forever begin
			@(negedge clk);
			cycles++;
			assert (uut.u_props.failures == 0) else begin
				$display("AXI protocol property failed before %0t ns", $time);
				stop_on_failure();
			end
			if (cycles > cycle_limit) begin
				$display("timeout after %0d cycles without reaching halt", cycles);
				stop_on_failure();
			end
		end
	end

	initial begin
		{awready, wready, bvalid, arready, rvalid} = 5'b00000;
		bresp   = 2'b00;
		rresp   = 2'b00;
		rdata   = 32'h0;
		reset   = 1'b1;
		wr_idx  = 0;
		aw_wait = pick_delay();
		w_wait  = pick_delay();
		ar_wait = pick_delay();
		load_golden();
		repeat (5) @(negedge clk);
		reset = 1'b0;
		while (!halted) @(negedge clk);
		if (uut.u_props.failures != 0) begin
			$display("%0d AXI protocol property failures", uut.u_props.failures);
			stop_on_failure();
		end else if (wr_idx == exp_addr.size()) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("halted after %0d of %0d expected writes", wr_idx, exp_addr.size());
			stop_on_failure();
		end
	end

endmodule

`default_nettype wire

// ==== test/sm83_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_props (
	input logic        clk,
	input logic        reset,
	input logic        awvalid,
	input logic        awready,
	input logic [15:0] awaddr,
	input logic        wvalid,
	input logic        wready,
	input logic [31:0] wdata,
	input logic [3:0]  wstrb,
	input logic        arvalid,
	input logic        arready,
	input logic        halted
);

	// count of failed properties
	int failures = 0;

	// ------------------------------
	// valid holds until ready
	// ------------------------------
	aw_hold: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid) else begin
		$error("awvalid dropped early");
		failures++;
	end
	w_hold: assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> wvalid) else begin
		$error("wvalid dropped early");
		failures++;
	end
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid) else begin
		$error("arvalid dropped early");
		failures++;
	end

	// payload steady while waiting
	aw_stable: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> $stable(awaddr)) else begin
		$error("awaddr moved");
		failures++;
	end
	w_stable: assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> $stable(wdata)) else begin
		$error("wdata moved");
		failures++;
	end

	// single byte lane
	strb_onehot: assert property (@(posedge clk) disable iff (reset)
		wvalid |-> $onehot(wstrb)) else begin
		$error("wstrb not one-hot");
		failures++;
	end

	// bus quiet once halted
	halt_quiet: assert property (@(posedge clk) disable iff (reset)
		halted |-> !(awvalid || wvalid || arvalid)) else begin
		$error("bus active in halt");
		failures++;
	end

endmodule

bind sm83_core_top sm83_props u_props (
	.clk(clk), .reset(reset),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
	.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
	.arvalid(arvalid), .arready(arready), .halted(halted)
);

`default_nettype wire

// ==== hdl/sm83_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_core_top (
	input  logic        clk,
	input  logic        reset,
	output logic        awvalid,
	input  logic        awready,
	output logic [15:0] awaddr,
	output logic        wvalid,
	input  logic        wready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	input  logic        bvalid,
	output logic        bready,
	input  logic [1:0]  bresp,
	output logic        arvalid,
	input  logic        arready,
	output logic [15:0] araddr,
	input  logic        rvalid,
	output logic        rready,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	output logic        halted
);

	sm83_bus_if bus ();

	sm83_pkg::decode_t dec;
	sm83_pkg::alu_op_e alu_op;
	logic [7:0]        opcode;
	logic              bank_cb;
	logic [7:0]        alu_a;
	logic [7:0]        alu_b;
	logic [2:0]        alu_bit;
	logic [7:0]        alu_result;
	logic [7:0]        alu_flags;
	logic [2:0]        rd_sel;
	logic [7:0]        rd_data;
	logic [7:0]        acc;
	logic [15:0]       hl;
	logic [7:0]        flags;
	logic              wr_en;
	logic [2:0]        wr_sel;
	logic [7:0]        wr_data;
	logic              pair_en;
	logic [1:0]        pair_sel;
	logic [15:0]       pair_data;
	logic              flags_en;
	logic [7:0]        flags_data;

	// ------------------------------
	// sequencer and decode
	// ------------------------------
	sm83_control u_control (
		.clk(clk), .reset(reset), .bus(bus), .dec(dec),
		.opcode(opcode), .bank_cb(bank_cb),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_bit(alu_bit),
		.alu_result(alu_result), .alu_flags(alu_flags),
		.rd_sel(rd_sel), .rd_data(rd_data), .acc(acc), .hl(hl), .flags(flags),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
		.pair_en(pair_en), .pair_sel(pair_sel), .pair_data(pair_data),
		.flags_en(flags_en), .flags_data(flags_data), .halted(halted)
	);

	sm83_decode u_decode (
		.opcode(opcode),
		.bank_cb(bank_cb),
		.dec(dec)
	);

	// datapath
	sm83_alu u_alu (
		.op(alu_op), .a(alu_a), .b(alu_b), .bit_idx(alu_bit),
		.flags_in(flags), .result(alu_result), .flags_out(alu_flags)
	);

	sm83_regfile u_regfile (
		.clk(clk), .reset(reset),
		.rd_sel(rd_sel), .rd_data(rd_data), .acc(acc), .hl(hl),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
		.pair_en(pair_en), .pair_sel(pair_sel), .pair_data(pair_data),
		.flags(flags), .flags_en(flags_en), .flags_data(flags_data)
	);

	// byte requests out to AXI4-Lite
	sm83_bus_master u_bus_master (
		.clk(clk), .reset(reset), .bus(bus),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

endmodule

`default_nettype wire

// ==== hdl/sm83_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_control (
	input  logic              clk,
	input  logic              reset,
	sm83_bus_if.control       bus,
	input  sm83_pkg::decode_t dec,
	output logic [7:0]        opcode,
	output logic              bank_cb,
	// ALU
	output sm83_pkg::alu_op_e alu_op,
	output logic [7:0]        alu_a,
	output logic [7:0]        alu_b,
	output logic [2:0]        alu_bit,
	input  logic [7:0]        alu_result,
	input  logic [7:0]        alu_flags,
	// register file
	output logic [2:0]        rd_sel,
	input  logic [7:0]        rd_data,
	input  logic [7:0]        acc,
	input  logic [15:0]       hl,
	input  logic [7:0]        flags,
	output logic              wr_en,
	output logic [2:0]        wr_sel,
	output logic [7:0]        wr_data,
	output logic              pair_en,
	output logic [1:0]        pair_sel,
	output logic [15:0]       pair_data,
	output logic              flags_en,
	output logic [7:0]        flags_data,
	output logic              halted
);

	sm83_pkg::state_e state;
	sm83_pkg::state_e state_nx;
	logic [15:0]      pc;
	logic [7:0]       opcode_q;
	logic             cb_q;
	logic [7:0]       imm_lo_q;
	logic [7:0]       imm_hi_q;
	logic [7:0]       mem_q;
	logic [7:0]       wr_byte;
	logic             is_exec;
	logic             fetching;
	logic             cond_ok;

	assign is_exec  = (state == sm83_pkg::st_exec);
	assign fetching = (state == sm83_pkg::st_fetch || state == sm83_pkg::st_fetch_cb);
	assign halted   = (state == sm83_pkg::st_halted);

	// fetched byte goes straight to the decoder so the next step is picked on done
	assign opcode  = (fetching && bus.done) ? bus.rdata : opcode_q;
	assign bank_cb = (state == sm83_pkg::st_fetch_cb) || (state != sm83_pkg::st_fetch && cb_q);

	// ------------------------------
	// memory requests
	// ------------------------------
	assign bus.req   = !(is_exec || halted);
	assign bus.we    = (state == sm83_pkg::st_write_hl);
	assign bus.addr  = (state == sm83_pkg::st_read_hl || bus.we) ? hl : pc;
	assign bus.wdata = wr_byte;

	// operand b is (HL), n or a register, a is always A
	assign alu_op  = dec.alu_op;
	assign alu_a   = acc;
	assign alu_b   = dec.use_hl_src ? mem_q : (dec.has_imm8 ? imm_lo_q : rd_data);
	assign alu_bit = dec.bit_idx;

	// register writes only in exec
	assign rd_sel     = dec.src_sel;
	assign wr_en      = is_exec && dec.writes_reg;
	assign wr_sel     = dec.dst_sel;
	assign wr_data    = alu_result;
	assign pair_en    = is_exec && dec.op_class == sm83_pkg::op_ld_dd_nn;
	assign pair_sel   = opcode_q[5:4];
	assign pair_data  = {imm_hi_q, imm_lo_q};
	assign flags_en   = is_exec && dec.writes_flags;
	assign flags_data = alu_flags;

	// NZ, Z, NC, C
	always_comb begin
		case (dec.cond)
			2'd0: cond_ok = !flags[sm83_pkg::flag_z];
			2'd1: cond_ok = flags[sm83_pkg::flag_z];
			2'd2: cond_ok = !flags[sm83_pkg::flag_c];
			default: cond_ok = flags[sm83_pkg::flag_c];
		endcase
	end

	// ------------------------------
	// sequencer
	// ------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			sm83_pkg::st_fetch: begin
				if (bus.done) begin
					if (dec.op_class == sm83_pkg::op_cb_prefix)
						state_nx = sm83_pkg::st_fetch_cb;
					else if (dec.has_imm8 || dec.has_imm16)
						state_nx = sm83_pkg::st_imm_lo;
					else if (dec.use_hl_src)
						state_nx = sm83_pkg::st_read_hl;
					else
						state_nx = sm83_pkg::st_exec;
				end
			end
			sm83_pkg::st_fetch_cb: begin
				if (bus.done)
					state_nx = dec.use_hl_src ? sm83_pkg::st_read_hl : sm83_pkg::st_exec;
			end
			sm83_pkg::st_imm_lo: begin
				if (bus.done)
					state_nx = dec.has_imm16 ? sm83_pkg::st_imm_hi : sm83_pkg::st_exec;
			end
			sm83_pkg::st_imm_hi, sm83_pkg::st_read_hl: begin
				if (bus.done)
					state_nx = sm83_pkg::st_exec;
			end
			sm83_pkg::st_exec: begin
				if (dec.op_class == sm83_pkg::op_halt)
					state_nx = sm83_pkg::st_halted;
				else if (dec.use_hl_dst)
					state_nx = sm83_pkg::st_write_hl;
				else
					state_nx = sm83_pkg::st_fetch;
			end
			sm83_pkg::st_write_hl: begin
				if (bus.done)
					state_nx = sm83_pkg::st_fetch;
			end
			// halted until reset
			default: state_nx = state;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sm83_pkg::st_fetch;
			pc    <= sm83_pkg::reset_pc;
			cb_q  <= 1'b0;
		end else begin
			state <= state_nx;
			// opcode, CB byte and immediates all step PC
			if (bus.done && state != sm83_pkg::st_read_hl && !bus.we)
				pc <= pc + 16'd1;
			if (fetching && bus.done)
				cb_q <= (state == sm83_pkg::st_fetch_cb);
			if (is_exec && dec.op_class == sm83_pkg::op_jp)
				pc <= {imm_hi_q, imm_lo_q};
			// PC already past the offset byte
			if (is_exec && dec.op_class == sm83_pkg::op_jr && (!dec.is_cond || cond_ok))
				pc <= pc + {{8{imm_lo_q[7]}}, imm_lo_q};
		end
	end

	// byte latches
	always_ff @(posedge clk) begin
		if (bus.done) begin
			case (state)
				sm83_pkg::st_fetch, sm83_pkg::st_fetch_cb: opcode_q <= bus.rdata;
				sm83_pkg::st_imm_lo: imm_lo_q <= bus.rdata;
				sm83_pkg::st_imm_hi: imm_hi_q <= bus.rdata;
				sm83_pkg::st_read_hl: mem_q <= bus.rdata;
				default: mem_q <= mem_q;
			endcase
		end
		// result held for write_hl, F may change under it
		if (is_exec)
			wr_byte <= alu_result;
	end

endmodule

`default_nettype wire

// ==== hdl/sm83_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_bus_master (
	input  logic              clk,
	input  logic              reset,
	sm83_bus_if.master        bus,
	// write address
	output logic              awvalid,
	input  logic              awready,
	output logic [15:0]       awaddr,
	// write data
	output logic              wvalid,
	input  logic              wready,
	output logic [31:0]       wdata,
	output logic [3:0]        wstrb,
	// write response
	input  logic              bvalid,
	output logic              bready,
	input  logic [1:0]        bresp,
	// read address
	output logic              arvalid,
	input  logic              arready,
	output logic [15:0]       araddr,
	// read data
	input  logic              rvalid,
	output logic              rready,
	input  logic [31:0]       rdata,
	input  logic [1:0]        rresp
);

	logic       wr_busy;
	logic       rd_busy;
	logic       start;
	logic [1:0] lane_q;

	// responses are always taken
	assign bready = 1'b1;
	assign rready = 1'b1;

	assign start = bus.req && !wr_busy && !rd_busy;

	// OKAY/EXOKAY finish the byte, an error response replays it
	assign bus.done  = (wr_busy && bvalid && !bresp[1]) || (rd_busy && rvalid && !rresp[1]);
	assign bus.rdata = rdata[{lane_q, 3'b000} +: 8];

	// ------------------------------
	// channel valids
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_busy <= 1'b0;
			rd_busy <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			// AW and W go up together
			if (start && bus.we) begin
				wr_busy <= 1'b1;
				awvalid <= 1'b1;
				wvalid  <= 1'b1;
			end
			if (start && !bus.we) begin
				rd_busy <= 1'b1;
				arvalid <= 1'b1;
			end
			// each drops on its own ready
			if (awvalid && awready) begin
				awvalid <= 1'b0;
			end
			if (wvalid && wready) begin
				wvalid <= 1'b0;
			end
			if (arvalid && arready) begin
				arvalid <= 1'b0;
			end
			if (wr_busy && bvalid) begin
				wr_busy <= bresp[1];
				awvalid <= bresp[1];
				wvalid  <= bresp[1];
			end
			if (rd_busy && rvalid) begin
				rd_busy <= rresp[1];
				arvalid <= rresp[1];
			end
		end
	end

	// address and lane steering, held for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			awaddr <= bus.addr;
			araddr <= bus.addr;
			wdata  <= {4{bus.wdata}};
			wstrb  <= 4'b0001 << bus.addr[1:0];
			lane_q <= bus.addr[1:0];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sm83_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_regfile (
	input  logic        clk,
	input  logic        reset,
	input  logic [2:0]  rd_sel,
	output logic [7:0]  rd_data,
	output logic [7:0]  acc,
	output logic [15:0] hl,
	input  logic        wr_en,
	input  logic [2:0]  wr_sel,
	input  logic [7:0]  wr_data,
	input  logic        pair_en,
	input  logic [1:0]  pair_sel,
	input  logic [15:0] pair_data,
	output logic [7:0]  flags,
	input  logic        flags_en,
	input  logic [7:0]  flags_data
);

	// B C D E H L - A, slot 6 is (HL) and stays zero
	logic [7:0] gpr [0:7];
	// ZNHC
	logic [3:0] f_hi;

	assign rd_data = gpr[rd_sel];
	assign acc     = gpr[7];
	assign hl      = {gpr[4], gpr[5]};
	assign flags   = {f_hi, 4'b0000};

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				gpr[i] <= 8'h00;
			end
			f_hi <= 4'h0;
		end else begin
			if (wr_en && wr_sel != 3'd6) begin
				gpr[wr_sel] <= wr_data;
			end
			// pair 0 BC, 1 DE, 2 HL, high byte at the even slot
			if (pair_en && pair_sel != 2'd3) begin
				gpr[{pair_sel, 1'b0}] <= pair_data[15:8];
				gpr[{pair_sel, 1'b1}] <= pair_data[7:0];
			end
			if (flags_en) begin
				f_hi <= flags_data[7:4];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sm83_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_alu (
	input  sm83_pkg::alu_op_e op,
	input  logic [7:0]        a,
	input  logic [7:0]        b,
	input  logic [2:0]        bit_idx,
	input  logic [7:0]        flags_in,
	output logic [7:0]        result,
	output logic [7:0]        flags_out
);

	logic       c_in;
	logic       carry;
	logic [8:0] add_sum;
	logic [4:0] add_half;
	logic [8:0] sub_sum;
	logic [4:0] sub_half;
	logic       z;
	logic       n;
	logic       h;
	logic       c;

	assign c_in  = flags_in[sm83_pkg::flag_c];
	// carry in only for adc and sbc
	assign carry = c_in && (op == sm83_pkg::alu_adc || op == sm83_pkg::alu_sbc);

	// half carry out of bit 3, carry out of bit 7
	assign add_sum  = {1'b0, a} + {1'b0, b} + {8'd0, carry};
	assign add_half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, carry};
	// borrow shows up in the top bit
	assign sub_sum  = {1'b0, a} - {1'b0, b} - {8'd0, carry};
	assign sub_half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, carry};

	always_comb begin
		// pass, res and set keep F as is
		result = b;
		z      = flags_in[sm83_pkg::flag_z];
		n      = flags_in[sm83_pkg::flag_n];
		h      = flags_in[sm83_pkg::flag_h];
		c      = c_in;
		case (op)
			sm83_pkg::alu_add, sm83_pkg::alu_adc: begin
				result = add_sum[7:0];
				z      = (add_sum[7:0] == 8'h00);
				n      = 1'b0;
				h      = add_half[4];
				c      = add_sum[8];
			end
			sm83_pkg::alu_sub, sm83_pkg::alu_sbc, sm83_pkg::alu_cp: begin
				// cp only compares
				result = (op == sm83_pkg::alu_cp) ? a : sub_sum[7:0];
				z      = (sub_sum[7:0] == 8'h00);
				n      = 1'b1;
				h      = sub_half[4];
				c      = sub_sum[8];
			end
			sm83_pkg::alu_and, sm83_pkg::alu_xor, sm83_pkg::alu_or: begin
				case (op)
					sm83_pkg::alu_and: result = a & b;
					sm83_pkg::alu_xor: result = a ^ b;
					default: result = a | b;
				endcase
				z = (result == 8'h00);
				n = 1'b0;
				// AND alone sets H
				h = (op == sm83_pkg::alu_and);
				c = 1'b0;
			end
			sm83_pkg::alu_inc, sm83_pkg::alu_dec: begin
				// C untouched
				result = (op == sm83_pkg::alu_inc) ? b + 8'd1 : b - 8'd1;
				z      = (result == 8'h00);
				n      = (op == sm83_pkg::alu_dec);
				h      = (op == sm83_pkg::alu_inc) ? (b[3:0] == 4'hf) : (b[3:0] == 4'h0);
			end
			sm83_pkg::alu_cpl: begin
				result = ~a;
				n      = 1'b1;
				h      = 1'b1;
			end
			sm83_pkg::alu_scf, sm83_pkg::alu_ccf: begin
				result = a;
				n      = 1'b0;
				h      = 1'b0;
				c      = (op == sm83_pkg::alu_scf) ? 1'b1 : !c_in;
			end
			sm83_pkg::alu_rlc, sm83_pkg::alu_rrc, sm83_pkg::alu_rl, sm83_pkg::alu_rr,
			sm83_pkg::alu_sla, sm83_pkg::alu_sra, sm83_pkg::alu_swap, sm83_pkg::alu_srl: begin
				// left shifts drop bit 7 into C, right shifts bit 0
				c = op[0] ? b[0] : b[7];
				case (op)
					sm83_pkg::alu_rlc: result = {b[6:0], b[7]};
					sm83_pkg::alu_rrc: result = {b[0], b[7:1]};
					sm83_pkg::alu_rl: result = {b[6:0], c_in};
					sm83_pkg::alu_rr: result = {c_in, b[7:1]};
					sm83_pkg::alu_sla: result = {b[6:0], 1'b0};
					sm83_pkg::alu_sra: result = {b[7], b[7:1]};
					sm83_pkg::alu_swap: begin
						result = {b[3:0], b[7:4]};
						c      = 1'b0;
					end
					default: result = {1'b0, b[7:1]};
				endcase
				z = (result == 8'h00);
				n = 1'b0;
				h = 1'b0;
			end
			sm83_pkg::alu_bit: begin
				z = !b[bit_idx];
				n = 1'b0;
				h = 1'b1;
			end
			sm83_pkg::alu_res: result = b & ~(8'd1 << bit_idx);
			sm83_pkg::alu_set: result = b | (8'd1 << bit_idx);
			default: result = b;
		endcase

		// low nibble of F stays zero
		flags_out                   = 8'h00;
		flags_out[sm83_pkg::flag_z] = z;
		flags_out[sm83_pkg::flag_n] = n;
		flags_out[sm83_pkg::flag_h] = h;
		flags_out[sm83_pkg::flag_c] = c;
	end

endmodule

`default_nettype wire

// ==== hdl/sm83_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_decode (
	input  logic [7:0]        opcode,
	input  logic              bank_cb,
	output sm83_pkg::decode_t dec
);

	logic [2:0] y;
	logic [2:0] z;
	logic       y_hl;
	logic       z_hl;

	// y = bits 5:3, z = bits 2:0
	assign y    = opcode[5:3];
	assign z    = opcode[2:0];
	assign y_hl = (y == 3'd6);
	assign z_hl = (z == 3'd6);

	always_comb begin
		dec          = '0;
		dec.op_class = sm83_pkg::op_nop;
		dec.alu_op   = sm83_pkg::alu_pass;
		dec.bit_idx  = y;
		// NZ Z NC C
		dec.cond     = opcode[4:3];

		if (bank_cb) begin
			// ------------------------------
			// CB bank, operand in z
			// ------------------------------
			dec.op_class   = sm83_pkg::op_cb_op;
			dec.src_sel    = z;
			dec.dst_sel    = z;
			dec.use_hl_src = z_hl;
			dec.use_hl_dst = z_hl && opcode[7:6] != 2'd1;
			dec.writes_reg = !z_hl && opcode[7:6] != 2'd1;
			case (opcode[7:6])
				2'd0: begin
					// rotate row, shift type in y
					dec.alu_op       = sm83_pkg::alu_op_e'({2'b01, y});
					dec.writes_flags = 1'b1;
				end
				2'd1: begin
					dec.alu_op       = sm83_pkg::alu_bit;
					dec.writes_flags = 1'b1;
				end
				2'd2: dec.alu_op = sm83_pkg::alu_res;
				default: dec.alu_op = sm83_pkg::alu_set;
			endcase
		end else begin
			// ------------------------------
			// unprefixed bank
			// ------------------------------
			case (opcode[7:6])
				2'd0: begin
					case (z)
						3'd0: begin
							// 18 JR e, 20/28/30/38 JR cc,e
							if (opcode == 8'h18 || opcode[5]) begin
								dec.op_class = sm83_pkg::op_jr;
								dec.has_imm8 = 1'b1;
								dec.is_cond  = opcode[5];
							end
						end
						3'd1: begin
							// LD BC/DE/HL,nn; LD SP,nn dropped
							if (!opcode[3] && opcode[5:4] != 2'd3) begin
								dec.op_class  = sm83_pkg::op_ld_dd_nn;
								dec.has_imm16 = 1'b1;
							end
						end
						3'd4, 3'd5: begin
							dec.op_class     = sm83_pkg::op_incdec;
							dec.alu_op       = z[0] ? sm83_pkg::alu_dec : sm83_pkg::alu_inc;
							dec.src_sel      = y;
							dec.dst_sel      = y;
							dec.use_hl_src   = y_hl;
							dec.use_hl_dst   = y_hl;
							dec.writes_reg   = !y_hl;
							dec.writes_flags = 1'b1;
						end
						3'd6: begin
							// LD r,n and LD (HL),n
							dec.op_class   = sm83_pkg::op_ld_rn;
							dec.has_imm8   = 1'b1;
							dec.dst_sel    = y;
							dec.use_hl_dst = y_hl;
							dec.writes_reg = !y_hl;
						end
						3'd7: begin
							// 2F CPL, 37 SCF, 3F CCF
							if (y >= 3'd5) begin
								dec.op_class     = sm83_pkg::op_misc_flag;
								dec.dst_sel      = 3'd7;
								dec.writes_reg   = (y == 3'd5);
								dec.writes_flags = 1'b1;
								case (y)
									3'd5: dec.alu_op = sm83_pkg::alu_cpl;
									3'd6: dec.alu_op = sm83_pkg::alu_scf;
									default: dec.alu_op = sm83_pkg::alu_ccf;
								endcase
							end
						end
						default: dec.op_class = sm83_pkg::op_nop;
					endcase
				end
				2'd1: begin
					if (opcode == 8'h76) begin
						dec.op_class = sm83_pkg::op_halt;
					end else begin
						dec.op_class   = sm83_pkg::op_ld_rr;
						dec.src_sel    = z;
						dec.dst_sel    = y;
						dec.use_hl_src = z_hl;
						dec.use_hl_dst = y_hl;
						dec.writes_reg = !y_hl;
					end
				end
				default: begin
					// row 2 is ALU r/(HL), row 3 column 6/E is ALU n
					if (opcode[7:6] == 2'd2 || z_hl) begin
						dec.op_class     = sm83_pkg::op_alu;
						dec.alu_op       = sm83_pkg::alu_op_e'({2'b00, y});
						dec.src_sel      = z;
						dec.dst_sel      = 3'd7;
						dec.use_hl_src   = z_hl && !opcode[6];
						dec.has_imm8     = opcode[6];
						// CP keeps A
						dec.writes_reg   = (y != 3'd7);
						dec.writes_flags = 1'b1;
					end else if (opcode == 8'hc3) begin
						dec.op_class  = sm83_pkg::op_jp;
						dec.has_imm16 = 1'b1;
					end else if (opcode == 8'hcb) begin
						dec.op_class = sm83_pkg::op_cb_prefix;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sm83_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// byte requests from the sequencer to the AXI master
interface sm83_bus_if;

	logic        req;
	logic        we;
	logic [15:0] addr;
	logic [7:0]  wdata;
	// read byte, valid with done
	logic [7:0]  rdata;
	// one-cycle end of transfer
	logic        done;

	modport control (
		output req, we, addr, wdata,
		input  rdata, done
	);

	modport master (
		input  req, we, addr, wdata,
		output rdata, done
	);

endinterface

`default_nettype wire

// ==== hdl/sm83_pkg.sv ====
`default_nettype none

package sm83_pkg;

	// ------------------------------
	// opcode classes and ALU ops
	// ------------------------------

	// instruction family, set by the decoder
	typedef enum logic [3:0] {
		op_nop, op_alu, op_incdec, op_misc_flag,
		op_ld_rr, op_ld_rn, op_ld_dd_nn, op_jp,
		op_jr, op_halt, op_cb_prefix, op_cb_op
	} op_class_e;

	// 0..7 follow opcode bits 5:3 of the ALU rows
	// 8..15 follow bits 5:3 of the CB shift row
	typedef enum logic [4:0] {
		alu_add, alu_adc, alu_sub, alu_sbc,
		alu_and, alu_xor, alu_or, alu_cp,
		alu_rlc, alu_rrc, alu_rl, alu_rr,
		alu_sla, alu_sra, alu_swap, alu_srl,
		alu_inc, alu_dec, alu_cpl, alu_scf, alu_ccf,
		alu_bit, alu_res, alu_set, alu_pass
	} alu_op_e;

	// ------------------------------
	// sequencer states
	// ------------------------------
	typedef enum logic [3:0] {
		st_fetch, st_fetch_cb, st_imm_lo, st_imm_hi,
		st_read_hl, st_exec, st_write_hl, st_halted
	} state_e;

	// register fields use the SM83 encoding, 6 stands for (HL)
	typedef struct packed {
		op_class_e  op_class;
		alu_op_e    alu_op;
		logic [2:0] src_sel;
		logic [2:0] dst_sel;
		logic       use_hl_src;
		logic       use_hl_dst;
		logic       has_imm8;
		logic       has_imm16;
		logic [1:0] cond;
		logic       is_cond;
		logic [2:0] bit_idx;
		logic       writes_reg;
		logic       writes_flags;
	} decode_t;

	// flag bits in F
	localparam int flag_z = 7;
	localparam int flag_n = 6;
	localparam int flag_h = 5;
	localparam int flag_c = 4;

	// first fetch address
	localparam logic [15:0] reset_pc = 16'h0000;

endpackage

`default_nettype wire
